// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tb_l1d_ctrl
FILELIST  = l1d_ctrl.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: dv/l1d_ctrl_properties.sv
module l1d_ctrl_properties import l1d_pkg::*; (
    input logic      clk,
    input logic      nrst,
    input cpu_resp_t cpu_resp,
    input logic      stall,
    input logic      refill,
    input l2_req_t   l2_req,
    input logic      l2_ack
);

    timeunit 1ns;
    timeprecision 100ps;

    // Four-phase req held with its fields until ack rises
    req_held_until_ack: assert property (
        @(posedge clk) disable iff (!nrst)
        l2_req.req && !l2_ack |=>
            l2_req.req && $stable({l2_req.write, l2_req.tag, l2_req.index})
    ) else $error("L2 request dropped or changed before ack");

    req_waits_for_ack_low: assert property (
        @(posedge clk) disable iff (!nrst)
        !l2_req.req && l2_ack |=> !l2_req.req  // Old transfer not closed yet
    ) else $error("L2 request raised while ack still high");

    done_not_while_stalled: assert property (
        @(posedge clk) disable iff (!nrst)
        !(cpu_resp.done && stall)
    ) else $error("CPU done and stall high together");

    refill_not_during_req: assert property (
        @(posedge clk) disable iff (!nrst)
        !(refill && l2_req.req)
    ) else $error("Refill pulse while L2 request high");

endmodule

bind l1d_ctrl l1d_ctrl_properties u_properties (
    .clk      (clk),
    .nrst     (nrst),
    .cpu_resp (cpu_resp),
    .stall    (stall),
    .refill   (refill),
    .l2_req   (l2_req),
    .l2_ack   (l2_ack)
);

// File: dv/l1d_tests.txt
# op tag index exp_hit exp_wb exp_wb_tag, numbers in hex
# op is R read, W write or F flush; a flush ignores the other columns
R 00abc 05 0 0 00000
R 00abc 05 1 0 00000
W 00abc 05 1 0 00000
R 01234 05 0 1 00abc
R 01234 05 1 0 00000
# Write miss allocates dirty
W 0beef 12 0 0 00000
W 0beef 12 1 0 00000
R 0cafe 12 0 1 0beef
R 0cafe 12 1 0 00000
W 0cafe 12 1 0 00000
R 00001 3f 0 0 00000
# Dirty line at 12 is dropped
F 00000 00 0 0 00000
R 0cafe 12 0 0 00000
R 00001 3f 0 0 00000
R 0cafe 12 1 0 00000
W 11111 00 0 0 00000
R 22222 00 0 1 11111
W 22222 00 1 0 00000
W 33333 00 0 1 22222
R 33333 00 1 0 00000
R 44444 01 0 0 00000
R 55555 01 0 0 00000
R 44444 01 0 0 00000
W 44444 01 1 0 00000
F 00000 00 0 0 00000
R 44444 01 0 0 00000
W 66666 2a 0 0 00000
R 66666 2a 1 0 00000
W 77777 2a 0 1 66666
R 66666 2a 0 1 77777
R 77777 2a 0 0 00000
R 00abc 05 0 0 00000
W 00abc 05 1 0 00000
R 01234 05 0 1 00abc
W 01234 05 1 0 00000
R 01234 05 1 0 00000
W fffff 3f 0 0 00000
R 00002 3f 0 1 fffff

// File: dv/tb_l1d_ctrl.sv
module tb_l1d_ctrl import l1d_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 200;

    // One L2 transfer as seen by the responder
    typedef struct packed {
        logic   write;
        tag_t   tag;
        index_t index;
    } xfer_t;

    logic      clk = 1'b0;
    logic      nrst;
    cpu_req_t  cpu_req;
    logic      flush;
    cpu_resp_t cpu_resp;
    logic      stall;
    logic      refill;
    l2_req_t   l2_req;
    logic      l2_ack = 1'b0;

    integer seed = 32'hc40f_2bf5;
    xfer_t  xfer_log[$];

    l1d_ctrl DUT (
        .clk      (clk),
        .nrst     (nrst),
        .cpu_req  (cpu_req),
        .flush    (flush),
        .cpu_resp (cpu_resp),
        .stall    (stall),
        .refill   (refill),
        .l2_req   (l2_req),
        .l2_ack   (l2_ack)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0d ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0d ns: %s never came within %0d cycles", $time, what, TIMEOUT);
        abort_run();
    endtask

    task automatic wait_drive_point();
        @(posedge clk);
        #1;
    endtask

    // Random ack delay, then hold ack until req falls
    task automatic serve_l2();
        xfer_t xfer;
        int    delay;
        int    cycles;
        xfer.write = l2_req.write;
        xfer.tag   = l2_req.tag;
        xfer.index = l2_req.index;
        xfer_log.push_back(xfer);
        delay = $unsigned($random(seed)) % 4;
        repeat (delay + 1) @(posedge clk);
        #1;
        l2_ack = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (l2_req.req && cycles == TIMEOUT)
                report_timeout("L2 request falling after ack");
        end while (l2_req.req);
        wait_drive_point();
        l2_ack = 1'b0;
    endtask

    always begin
        @(negedge clk);
        if (nrst && l2_req.req && !l2_ack)
            serve_l2();
    end

    task automatic run_access(input logic write, input tag_t tag, input index_t index,
                              input logic exp_hit, input logic exp_wb, input tag_t wb_tag);
        int    cycles;
        int    refills;
        logic  stall_seen;
        logic  got_done;
        xfer_t xfer;
        xfer_log.delete();
        cycles     = 0;
        refills    = 0;
        stall_seen = 1'b0;
        got_done   = 1'b0;
        cpu_req.valid = 1'b1;
        cpu_req.write = write;
        cpu_req.tag   = tag;
        cpu_req.index = index;
        while (!got_done) begin
            @(negedge clk);
            cycles++;
            got_done = cpu_resp.done;
            if (refill)
                refills++;
            if (stall)
                stall_seen = 1'b1;
            if (!got_done && cycles == TIMEOUT)
                report_timeout("CPU done");
        end
        check_value(32'(cpu_resp.hit), 32'(exp_hit), "hit flag");
        if (exp_hit) begin
            check_value(32'(cycles), 32'd2, "hit latency");  // Idle cycle, then compare
            check_value(32'(xfer_log.size()), 32'd0, "L2 transfers on hit");
            check_value(32'(refills), 32'd0, "refill pulses on hit");
            check_value(32'(stall_seen), 32'd0, "stall on hit");
        end else begin
            check_value(32'(xfer_log.size()), 32'(exp_wb) + 32'd1, "L2 transfers on miss");
            if (exp_wb) begin
                xfer = xfer_log.pop_front();
                check_value(32'(xfer.write), 32'd1, "write-back direction");
                check_value(32'(xfer.tag), 32'(wb_tag), "write-back tag");
                check_value(32'(xfer.index), 32'(index), "write-back index");
            end
            xfer = xfer_log.pop_front();  // Allocate comes last
            check_value(32'(xfer.write), 32'd0, "allocate direction");
            check_value(32'(xfer.tag), 32'(tag), "allocate tag");
            check_value(32'(xfer.index), 32'(index), "allocate index");
            check_value(32'(refills), 32'd1, "refill pulses on miss");
            check_value(32'(stall_seen), 32'd1, "stall on miss");
        end
        wait_drive_point();
        cpu_req = '0;
    endtask

    task automatic run_flush();
        flush = 1'b1;
        wait_drive_point();
        flush = 1'b0;
    endtask

    initial begin
        int         fd;
        int         fields;
        int         ops;
        string      line;
        logic [7:0] op;
        tag_t       tag;
        index_t     index;
        logic       exp_hit;
        logic       exp_wb;
        tag_t       wb_tag;
        ops     = 0;
        nrst    = 1'b0;
        cpu_req = '0;
        flush   = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        nrst = 1'b1;
        @(negedge clk);
        check_value(32'(cpu_resp.done), 32'd0, "done after reset");
        check_value(32'(stall), 32'd0, "stall after reset");
        check_value(32'(refill), 32'd0, "refill after reset");
        check_value(32'(l2_req.req), 32'd0, "L2 request after reset");

        fd = $fopen("dv/l1d_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file dv/l1d_tests.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line   = "";
            fields = $fgets(line, fd);
            if (line.len() <= 1 || line.getc(0) == "#")
                continue;
            fields = $sscanf(line, "%c %h %h %h %h %h",
                             op, tag, index, exp_hit, exp_wb, wb_tag);
            if (fields != 6) begin
                $display("Malformed line in the test file: %s", line);
                abort_run();
            end
            wait_drive_point();
            case (op)
                "R": run_access(1'b0, tag, index, exp_hit, exp_wb, wb_tag);
                "W": run_access(1'b1, tag, index, exp_hit, exp_wb, wb_tag);
                "F": run_flush();
                default: begin
                    $display("Unknown opcode %c in the test file", op);
                    abort_run();
                end
            endcase
            ops++;
        end
        $fclose(fd);
        check_value(32'(ops != 0), 32'd1, "operations read from the test file");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: l1d_ctrl.f
source/l1d_pkg.sv
source/tag_store.sv
source/miss_fsm.sv
source/l1d_ctrl.sv
dv/l1d_ctrl_properties.sv
dv/tb_l1d_ctrl.sv

// File: source/l1d_ctrl.sv
module l1d_ctrl import l1d_pkg::*; (
    input  logic      clk,
    input  logic      nrst,
    input  cpu_req_t  cpu_req,
    input  logic      flush,
    output cpu_resp_t cpu_resp,
    output logic      stall,
    output logic      refill,
    output l2_req_t   l2_req,
    input  logic      l2_ack
);

    index_t index;
    tag_t   lookup_tag;
    tag_t   victim_tag;
    logic   hit;
    logic   victim_dirty;
    logic   fill;
    logic   fill_dirty;
    logic   mark_dirty;
    logic   clear_all;

    tag_store u_tag_store (
        .clk          (clk),
        .nrst         (nrst),
        .index        (index),
        .lookup_tag   (lookup_tag),
        .fill         (fill),
        .fill_dirty   (fill_dirty),
        .mark_dirty   (mark_dirty),
        .clear_all    (clear_all),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    miss_fsm u_miss_fsm (
        .clk          (clk),
        .nrst         (nrst),
        .cpu_req      (cpu_req),
        .flush        (flush),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .index        (index),
        .lookup_tag   (lookup_tag),
        .fill         (fill),
        .fill_dirty   (fill_dirty),
        .mark_dirty   (mark_dirty),
        .clear_all    (clear_all),
        .cpu_resp     (cpu_resp),
        .stall        (stall),
        .refill       (refill),
        .l2_req       (l2_req),
        .l2_ack       (l2_ack)
    );

endmodule

// File: source/l1d_pkg.sv
package l1d_pkg;

    // Cache geometry
    localparam int TAG_W     = 20;
    localparam int INDEX_W   = 6;
    localparam int NUM_LINES = 64;

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // Controller states
    typedef enum logic [1:0] {
        s_idle       = 2'b00,
        s_compare    = 2'b01,
        s_write_back = 2'b10,
        s_allocate   = 2'b11
    } ctrl_state_t;

    // CPU request, held by the CPU until done
    typedef struct packed {
        logic   valid;
        logic   write;
        tag_t   tag;
        index_t index;
    } cpu_req_t;

    typedef struct packed {
        logic done;
        logic hit;  // Only on the first compare
    } cpu_resp_t;

    // L2 side of the four-phase handshake
    typedef struct packed {
        logic   req;
        logic   write;  // 1 for write-back, 0 for allocate
        tag_t   tag;
        index_t index;
    } l2_req_t;

endpackage

// File: source/miss_fsm.sv
module miss_fsm import l1d_pkg::*; (
    input  logic      clk,
    input  logic      nrst,

    // CPU side
    input  cpu_req_t  cpu_req,
    input  logic      flush,

    // Tag store lookup results
    input  logic      hit,
    input  logic      victim_dirty,
    input  tag_t      victim_tag,

    // Tag store control
    output index_t    index,
    output tag_t      lookup_tag,
    output logic      fill,
    output logic      fill_dirty,
    output logic      mark_dirty,
    output logic      clear_all,

    output cpu_resp_t cpu_resp,
    output logic      stall,
    output logic      refill,

    // L2 four-phase port
    output l2_req_t   l2_req,
    input  logic      l2_ack
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    cpu_req_t    req_q;      // Accepted request
    logic        missed;     // First compare of this request missed
    logic        l2_busy;    // req up, ack not seen yet
    logic        accept;
    logic        in_xfer;
    logic        xfer_done;
    logic        compare_hit;

    assign accept      = (state == s_idle) && !flush && cpu_req.valid;
    assign in_xfer     = (state == s_write_back) || (state == s_allocate);
    assign compare_hit = (state == s_compare) && hit;

    // Ack seen and dropped again
    assign xfer_done = in_xfer && !l2_busy && !l2_ack;

    assign index      = req_q.index;
    assign lookup_tag = req_q.tag;

    always_comb begin
        next_state = state;
        case (state)
            s_idle: begin
                if (accept)
                    next_state = s_compare;
            end
            s_compare: begin
                if (hit)
                    next_state = s_idle;
                else if (victim_dirty)
                    next_state = s_write_back;
                else
                    next_state = s_allocate;
            end
            s_write_back: begin
                if (xfer_done)
                    next_state = s_allocate;
            end
            s_allocate: begin
                if (xfer_done)
                    next_state = s_compare;  // Compare again, now hits
            end
            default: next_state = s_idle;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state   <= s_idle;
            missed  <= 1'b0;
            l2_busy <= 1'b0;
        end else begin
            state <= next_state;

            if (state == s_idle)
                missed <= 1'b0;
            else if (state == s_compare && !hit)
                missed <= 1'b1;

            // Each entry into a transfer state starts one transfer
            if (next_state != state &&
                (next_state == s_write_back || next_state == s_allocate))
                l2_busy <= 1'b1;
            else if (l2_busy && l2_ack)
                l2_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            req_q <= cpu_req;
    end

    // Tag store control
    assign clear_all  = (state == s_idle) && flush;  // Busy flush is dropped
    assign mark_dirty = compare_hit && req_q.write;
    assign fill       = (state == s_allocate) && xfer_done;
    assign fill_dirty = req_q.write;

    assign refill = fill;
    assign stall  = in_xfer;

    assign cpu_resp.done = compare_hit;
    assign cpu_resp.hit  = compare_hit && !missed;

    // Victim tag stays put during write-back, nothing fills the line then
    always_comb begin
        l2_req.req   = l2_busy;
        l2_req.write = (state == s_write_back);
        l2_req.tag   = (state == s_write_back) ? victim_tag : req_q.tag;
        l2_req.index = req_q.index;
    end

endmodule

// File: source/tag_store.sv
module tag_store import l1d_pkg::*; (
    input  logic   clk,
    input  logic   nrst,

    // Addressed line
    input  index_t index,
    input  tag_t   lookup_tag,

    // Updates, applied at the next edge
    input  logic   fill,
    input  logic   fill_dirty,
    input  logic   mark_dirty,
    input  logic   clear_all,

    output logic   hit,
    output logic   victim_dirty,
    output tag_t   victim_tag
);

    tag_t                 tags [NUM_LINES];
    logic [NUM_LINES-1:0] valid;
    logic [NUM_LINES-1:0] dirty;

    tag_t stored_tag;
    logic line_valid;
    logic line_dirty;
    logic tag_match;

    // Lookup on the addressed line
    assign stored_tag = tags[index];
    assign line_valid = valid[index];
    assign line_dirty = dirty[index];
    assign tag_match  = (stored_tag == lookup_tag);

    assign hit          = line_valid && tag_match;
    assign victim_dirty = line_valid && line_dirty;  // Needs write-back on replace
    assign victim_tag   = stored_tag;

    // Tag array
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                tags[i] <= '0;
            end
        end else if (fill) begin
            tags[index] <= lookup_tag;
        end
    end

    // Valid and dirty bits
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid <= '0;
            dirty <= '0;
        end else if (clear_all) begin
            // Flush drops every line, dirty or not
            valid <= '0;
            dirty <= '0;
        end else if (fill) begin
            valid[index] <= 1'b1;
            dirty[index] <= fill_dirty;
        end else if (mark_dirty) begin
            dirty[index] <= 1'b1;  // Write hit
        end
    end

endmodule
